// File: rtl/vproc_defs.svh
`ifndef VPROC_DEFS_SVH
`define VPROC_DEFS_SVH

// Lane count, must be a power of two
`define VPROC_NR_LANES 4

// Elements of one vector register held in each lane
`define VPROC_ELEMS_PER_LANE 4

// Element and scalar operand width in bits
`define VPROC_ELEN 32

`define VPROC_NR_VREGS 8

// In-flight slots in the sequencer
`define VPROC_NR_VINSN 2

// Maximum vector length in elements
`define VPROC_VLMAX (`VPROC_NR_LANES * `VPROC_ELEMS_PER_LANE)

`endif

// File: rtl/vproc_pkg.sv
package vproc_pkg;

  `include "vproc_defs.svh"

  typedef logic [`VPROC_ELEN-1:0] elem_t;
  typedef logic [$clog2(`VPROC_NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(`VPROC_VLMAX+1)-1:0] vlen_t;
  typedef logic [$clog2(`VPROC_ELEMS_PER_LANE)-1:0] epos_t;
  // Element count within one lane, 0 up to ELEMS_PER_LANE
  typedef logic [$clog2(`VPROC_ELEMS_PER_LANE+1)-1:0] ecnt_t;
  typedef logic [$clog2(`VPROC_NR_VINSN)-1:0] vid_t;

  typedef enum logic [3:0] {
    VSETVL,
    VADD_VV,
    VAND_VV,
    VXOR_VV,
    VADD_VX,
    VMV_V_X,
    VSLIDE1UP_VX,
    VSLIDE1DOWN_VX,
    VMV_X_S
  } vop_e;

  typedef enum logic {
    IDLE,
    WAIT_SCALAR
  } disp_state_e;

  // Slides run in the slide unit, everything else in the lanes
  function automatic logic is_slide(vop_e op);
    return (op == VSLIDE1UP_VX) || (op == VSLIDE1DOWN_VX);
  endfunction

endpackage

// File: rtl/vproc_dispatcher.sv
`include "vproc_defs.svh"

module vproc_dispatcher import vproc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Core side
  input  logic  insn_valid_i,
  input  vop_e  insn_op_i,
  input  vreg_t insn_vd_i,
  input  vreg_t insn_vs1_i,
  input  vreg_t insn_vs2_i,
  input  elem_t insn_scalar_i,
  output logic  insn_ready_o,
  output logic  resp_valid_o,
  output elem_t resp_data_o,
  output logic  idle_o,
  // Sequencer side
  output logic  req_valid_o,
  output vop_e  req_op_o,
  output vreg_t req_vd_o,
  output vreg_t req_vs1_o,
  output vreg_t req_vs2_o,
  output elem_t req_scalar_o,
  output vlen_t req_vl_o,
  input  logic  req_ready_i,
  input  logic  scalar_valid_i,
  input  elem_t scalar_data_i,
  input  logic  seq_idle_i
);

  disp_state_e state_q;
  disp_state_e state_d;
  vlen_t       vl_q;
  vlen_t       vl_new;
  logic        resp_valid_q;
  elem_t       resp_data_q;
  logic        accept;
  logic        setvl;

  // Stall for one cycle behind a vsetvl so responses never touch
  assign insn_ready_o = (state_q == IDLE) && req_ready_i && !resp_valid_q;
  assign accept       = insn_valid_i && insn_ready_o;
  assign setvl        = accept && (insn_op_i == VSETVL);

  assign vl_new = (insn_scalar_i > elem_t'(`VPROC_VLMAX)) ? vlen_t'(`VPROC_VLMAX)
                                                          : vlen_t'(insn_scalar_i);

  // Everything but vsetvl goes on to the sequencer
  assign req_valid_o  = insn_valid_i && (state_q == IDLE) && !resp_valid_q &&
                        (insn_op_i != VSETVL);
  assign req_op_o     = insn_op_i;
  assign req_vd_o     = insn_vd_i;
  assign req_vs1_o    = insn_vs1_i;
  assign req_vs2_o    = insn_vs2_i;
  assign req_scalar_o = insn_scalar_i;
  assign req_vl_o     = vl_q;

  assign resp_valid_o = resp_valid_q || scalar_valid_i;
  assign resp_data_o  = resp_valid_q ? resp_data_q : scalar_data_i;
  assign idle_o       = (state_q == IDLE) && seq_idle_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (accept && insn_op_i == VMV_X_S) state_d = WAIT_SCALAR;
      WAIT_SCALAR: if (scalar_valid_i) state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      vl_q         <= vlen_t'(`VPROC_VLMAX);
      resp_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      resp_valid_q <= setvl;
      if (setvl) vl_q <= vl_new;
    end
  end

  always_ff @(posedge clk_i) begin
    if (setvl) resp_data_q <= elem_t'(vl_new);
  end

endmodule

// File: rtl/vproc_sequencer.sv
`include "vproc_defs.svh"

module vproc_sequencer import vproc_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Dispatcher side
  input  logic                              req_valid_i,
  input  vop_e                              req_op_i,
  input  vreg_t                             req_vd_i,
  input  vreg_t                             req_vs1_i,
  input  vreg_t                             req_vs2_i,
  input  elem_t                             req_scalar_i,
  input  vlen_t                             req_vl_i,
  output logic                              req_ready_o,
  output logic                              scalar_valid_o,
  output elem_t                             scalar_data_o,
  output logic                              seq_idle_o,
  // Broadcast to lanes and slide unit
  output logic                              pe_valid_o,
  output vid_t                              pe_id_o,
  output vop_e                              pe_op_o,
  output vreg_t                             pe_vd_o,
  output vreg_t                             pe_vs1_o,
  output vreg_t                             pe_vs2_o,
  output elem_t                             pe_scalar_o,
  output vlen_t                             pe_vl_o,
  input  logic  [`VPROC_NR_LANES-1:0]       lane_ready_i,
  input  logic  [`VPROC_NR_LANES-1:0]       lane_done_i,
  input  vid_t  [`VPROC_NR_LANES-1:0]       lane_done_id_i,
  input  logic                              sldu_ready_i,
  input  logic                              sldu_done_i,
  input  vid_t                              sldu_done_id_i,
  input  logic                              lane0_scalar_valid_i,
  input  elem_t                             lane0_scalar_data_i
);

  localparam int unsigned NrLanes = `VPROC_NR_LANES;
  localparam int unsigned NrVInsn = `VPROC_NR_VINSN;

  logic [NrVInsn-1:0] slot_valid_q;
  vreg_t              slot_vd_q    [NrVInsn];
  vreg_t              slot_vs1_q   [NrVInsn];
  vreg_t              slot_vs2_q   [NrVInsn];
  logic [NrLanes-1:0] lanes_done_q [NrVInsn];
  logic [NrLanes-1:0] lanes_done_d [NrVInsn];
  logic [NrVInsn-1:0] retire;
  logic               hazard;
  logic               slot_free;
  vid_t               free_id;
  logic               units_ready;
  logic               issue;

  //////////////////////////////////////////////////////////////////////
  // Hazard check and slot allocation
  //////////////////////////////////////////////////////////////////////

  // RAW and WAW on a running vd, WAR on a running source
  always_comb begin
    hazard = 1'b0;
    for (int unsigned s = 0; s < NrVInsn; s++) begin
      if (slot_valid_q[s] &&
          (req_vd_i == slot_vd_q[s] || req_vs1_i == slot_vd_q[s] ||
           req_vs2_i == slot_vd_q[s] || req_vd_i == slot_vs1_q[s] ||
           req_vd_i == slot_vs2_q[s])) begin
        hazard = 1'b1;
      end
    end
  end

  // Lowest free slot wins
  always_comb begin
    slot_free = 1'b0;
    free_id   = '0;
    for (int s = NrVInsn - 1; s >= 0; s--) begin
      if (!slot_valid_q[s]) begin
        slot_free = 1'b1;
        free_id   = vid_t'(s);
      end
    end
  end

  assign units_ready = is_slide(req_op_i) ? sldu_ready_i : &lane_ready_i;
  assign req_ready_o = slot_free && !hazard && units_ready;
  assign issue       = req_valid_i && req_ready_o;

  assign pe_valid_o  = issue;
  assign pe_id_o     = free_id;
  assign pe_op_o     = req_op_i;
  assign pe_vd_o     = req_vd_i;
  assign pe_vs1_o    = req_vs1_i;
  assign pe_vs2_o    = req_vs2_i;
  assign pe_scalar_o = req_scalar_i;
  assign pe_vl_o     = req_vl_i;

  //////////////////////////////////////////////////////////////////////
  // Completion tracking
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned s = 0; s < NrVInsn; s++) begin
      lanes_done_d[s] = lanes_done_q[s];
      for (int unsigned l = 0; l < NrLanes; l++) begin
        if (lane_done_i[l] && lane_done_id_i[l] == vid_t'(s)) lanes_done_d[s][l] = 1'b1;
      end
      retire[s] = slot_valid_q[s] &&
                  ((&lanes_done_d[s]) || (sldu_done_i && sldu_done_id_i == vid_t'(s)));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      slot_valid_q <= '0;
      for (int unsigned s = 0; s < NrVInsn; s++) lanes_done_q[s] <= '0;
    end else begin
      for (int unsigned s = 0; s < NrVInsn; s++) begin
        if (retire[s]) begin
          slot_valid_q[s] <= 1'b0;
          lanes_done_q[s] <= '0;
        end else begin
          lanes_done_q[s] <= lanes_done_d[s];
        end
      end
      if (issue) begin
        slot_valid_q[free_id] <= 1'b1;
        lanes_done_q[free_id] <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      slot_vd_q[free_id]  <= req_vd_i;
      slot_vs1_q[free_id] <= req_vs1_i;
      slot_vs2_q[free_id] <= req_vs2_i;
    end
  end

  // Element 0 comes back from lane 0 only
  assign scalar_valid_o = lane0_scalar_valid_i;
  assign scalar_data_o  = lane0_scalar_data_i;
  assign seq_idle_o     = ~|slot_valid_q;

endmodule

// File: rtl/vproc_lane.sv
`include "vproc_defs.svh"

module vproc_lane import vproc_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Sequencer broadcast
  input  logic  pe_valid_i,
  input  vid_t  pe_id_i,
  input  vop_e  pe_op_i,
  input  vreg_t pe_vd_i,
  input  vreg_t pe_vs1_i,
  input  vreg_t pe_vs2_i,
  input  elem_t pe_scalar_i,
  input  vlen_t pe_vl_i,
  output logic  lane_ready_o,
  output logic  lane_done_o,
  output vid_t  done_id_o,
  // Slide unit read port
  input  logic  rd_req_i,
  input  vreg_t rd_vreg_i,
  input  epos_t rd_pos_i,
  output elem_t rd_data_o,
  // Slide unit write port, always granted
  input  logic  wr_req_i,
  input  vreg_t wr_vreg_i,
  input  epos_t wr_pos_i,
  input  elem_t wr_data_i,
  // Scalar move result
  output logic  scalar_valid_o,
  output elem_t scalar_data_o
);

  localparam int unsigned NrLanes      = `VPROC_NR_LANES;
  localparam int unsigned ElemsPerLane = `VPROC_ELEMS_PER_LANE;
  localparam int unsigned NrVregs      = `VPROC_NR_VREGS;

  // Slice of the register file, [vreg][position]
  elem_t vrf_q [NrVregs][ElemsPerLane];

  logic  busy_q;
  vid_t  id_q;
  vop_e  op_q;
  vreg_t vd_q;
  vreg_t vs1_q;
  vreg_t vs2_q;
  elem_t scalar_q;
  ecnt_t cnt_q;
  ecnt_t pos_q;
  elem_t rd_data_q;
  logic  accept;
  logic  step;
  ecnt_t cnt_new;
  elem_t opa;
  elem_t opb;
  elem_t alu_res;

  assign lane_ready_o = !busy_q;
  assign accept       = pe_valid_i && !is_slide(pe_op_i);

  // Elements with index below vl that map onto this lane
  always_comb begin
    if (pe_op_i == VMV_X_S) begin
      cnt_new = (LaneId == 0) ? ecnt_t'(1) : ecnt_t'(0);
    end else begin
      cnt_new = ecnt_t'((pe_vl_i + NrLanes - 1 - LaneId) / NrLanes);
    end
  end

  // A slide write takes the VRF port, the ALU waits
  assign step        = busy_q && (pos_q != cnt_q) && !wr_req_i;
  assign lane_done_o = busy_q && (pos_q == cnt_q);
  assign done_id_o   = id_q;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  assign opa = vrf_q[vs2_q][epos_t'(pos_q)];
  assign opb = vrf_q[vs1_q][epos_t'(pos_q)];

  always_comb begin
    case (op_q)
      VADD_VV: alu_res = opa + opb;
      VAND_VV: alu_res = opa & opb;
      VXOR_VV: alu_res = opa ^ opb;
      VADD_VX: alu_res = opa + scalar_q;
      VMV_V_X: alu_res = scalar_q;
      default: alu_res = opa;
    endcase
  end

  assign scalar_valid_o = step && (op_q == VMV_X_S);
  assign scalar_data_o  = opa;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      pos_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      pos_q  <= '0;
    end else if (lane_done_o) begin
      busy_q <= 1'b0;
    end else if (step) begin
      pos_q <= pos_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q     <= pe_id_i;
      op_q     <= pe_op_i;
      vd_q     <= pe_vd_i;
      vs1_q    <= pe_vs1_i;
      vs2_q    <= pe_vs2_i;
      scalar_q <= pe_scalar_i;
      cnt_q    <= cnt_new;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file ports
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_req_i) begin
      vrf_q[wr_vreg_i][wr_pos_i] <= wr_data_i;
    end else if (step && op_q != VMV_X_S) begin
      vrf_q[vd_q][epos_t'(pos_q)] <= alu_res;
    end
    if (rd_req_i) rd_data_q <= vrf_q[rd_vreg_i][rd_pos_i];
  end

  assign rd_data_o = rd_data_q;

endmodule

// File: rtl/vproc_sldu.sv
`include "vproc_defs.svh"

module vproc_sldu import vproc_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Sequencer broadcast
  input  logic                        pe_valid_i,
  input  vid_t                        pe_id_i,
  input  vop_e                        pe_op_i,
  input  vreg_t                       pe_vd_i,
  input  vreg_t                       pe_vs2_i,
  input  elem_t                       pe_scalar_i,
  input  vlen_t                       pe_vl_i,
  output logic                        sldu_ready_o,
  output logic                        sldu_done_o,
  output vid_t                        done_id_o,
  // Lane ports
  output logic  [`VPROC_NR_LANES-1:0] rd_req_o,
  output vreg_t [`VPROC_NR_LANES-1:0] rd_vreg_o,
  output epos_t [`VPROC_NR_LANES-1:0] rd_pos_o,
  input  elem_t [`VPROC_NR_LANES-1:0] rd_data_i,
  output logic  [`VPROC_NR_LANES-1:0] wr_req_o,
  output vreg_t [`VPROC_NR_LANES-1:0] wr_vreg_o,
  output epos_t [`VPROC_NR_LANES-1:0] wr_pos_o,
  output elem_t [`VPROC_NR_LANES-1:0] wr_data_o
);

  localparam int unsigned NrLanes = `VPROC_NR_LANES;

  logic  busy_q;
  logic  up_q;
  logic  wvalid_q;
  vid_t  id_q;
  vreg_t vd_q;
  vreg_t vs2_q;
  elem_t scalar_q;
  vlen_t vl_q;
  ecnt_t npos_q;
  ecnt_t rpos_q;
  epos_t wpos_q;
  logic  accept;
  logic  rd_en;

  assign sldu_ready_o = !busy_q;
  assign accept       = pe_valid_i && is_slide(pe_op_i);
  assign rd_en        = busy_q && (rpos_q != npos_q);
  assign sldu_done_o  = busy_q && !rd_en && !wvalid_q;
  assign done_id_o    = id_q;

  // Read stage. The last lane looks one position back on slide-up
  // and lane 0 one position ahead on slide-down, where the ring wraps
  always_comb begin
    for (int unsigned l = 0; l < NrLanes; l++) begin
      rd_req_o[l]  = rd_en;
      rd_vreg_o[l] = vs2_q;
      rd_pos_o[l]  = epos_t'(rpos_q);
    end
    if (up_q) begin
      rd_pos_o[NrLanes-1] = epos_t'(rpos_q - 1'b1);
    end else begin
      rd_pos_o[0] = epos_t'(rpos_q + 1'b1);
    end
  end

  // Write stage, one cycle behind the read
  always_comb begin
    for (int unsigned l = 0; l < NrLanes; l++) begin
      wr_req_o[l]  = wvalid_q && ((wpos_q * NrLanes + l) < vl_q);
      wr_vreg_o[l] = vd_q;
      wr_pos_o[l]  = wpos_q;
      if (up_q) begin
        wr_data_o[l] = (l == 0 && wpos_q == '0) ? scalar_q
                                                : rd_data_i[(l + NrLanes - 1) % NrLanes];
      end else begin
        wr_data_o[l] = ((wpos_q * NrLanes + l + 1) == vl_q) ? scalar_q
                                                            : rd_data_i[(l + 1) % NrLanes];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      wvalid_q <= 1'b0;
      rpos_q   <= '0;
    end else begin
      wvalid_q <= rd_en;
      if (accept) begin
        busy_q <= 1'b1;
        rpos_q <= '0;
      end else if (sldu_done_o) begin
        busy_q <= 1'b0;
      end else if (rd_en) begin
        rpos_q <= rpos_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) wpos_q <= epos_t'(rpos_q);
    if (accept) begin
      id_q     <= pe_id_i;
      up_q     <= (pe_op_i == VSLIDE1UP_VX);
      vd_q     <= pe_vd_i;
      vs2_q    <= pe_vs2_i;
      scalar_q <= pe_scalar_i;
      vl_q     <= pe_vl_i;
      // Positions touched in each lane
      npos_q   <= ecnt_t'((pe_vl_i + NrLanes - 1) / NrLanes);
    end
  end

endmodule

// File: rtl/vproc_top.sv
`include "vproc_defs.svh"

module vproc_top import vproc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  insn_valid_i,
  input  vop_e  insn_op_i,
  input  vreg_t insn_vd_i,
  input  vreg_t insn_vs1_i,
  input  vreg_t insn_vs2_i,
  input  elem_t insn_scalar_i,
  output logic  insn_ready_o,
  output logic  resp_valid_o,
  output elem_t resp_data_o,
  output logic  idle_o
);

  localparam int unsigned NrLanes = `VPROC_NR_LANES;

  // Dispatcher to sequencer
  logic  req_valid;
  logic  req_ready;
  vop_e  req_op;
  vreg_t req_vd;
  vreg_t req_vs1;
  vreg_t req_vs2;
  elem_t req_scalar;
  vlen_t req_vl;
  logic  scalar_valid;
  elem_t scalar_data;
  logic  seq_idle;

  // Sequencer broadcast and completions
  logic                pe_valid;
  vid_t                pe_id;
  vop_e                pe_op;
  vreg_t               pe_vd;
  vreg_t               pe_vs1;
  vreg_t               pe_vs2;
  elem_t               pe_scalar;
  vlen_t               pe_vl;
  logic  [NrLanes-1:0] lane_ready;
  logic  [NrLanes-1:0] lane_done;
  vid_t  [NrLanes-1:0] lane_done_id;
  logic  [NrLanes-1:0] lane_scalar_valid;
  elem_t [NrLanes-1:0] lane_scalar_data;
  logic                sldu_ready;
  logic                sldu_done;
  vid_t                sldu_done_id;

  // Slide unit to lanes
  logic  [NrLanes-1:0] rd_req;
  vreg_t [NrLanes-1:0] rd_vreg;
  epos_t [NrLanes-1:0] rd_pos;
  elem_t [NrLanes-1:0] rd_data;
  logic  [NrLanes-1:0] wr_req;
  vreg_t [NrLanes-1:0] wr_vreg;
  epos_t [NrLanes-1:0] wr_pos;
  elem_t [NrLanes-1:0] wr_data;

  vproc_dispatcher i_dispatcher (
    .clk_i          (clk_i         ),
    .rst_n_i        (rst_n_i       ),
    .insn_valid_i   (insn_valid_i  ),
    .insn_op_i      (insn_op_i     ),
    .insn_vd_i      (insn_vd_i     ),
    .insn_vs1_i     (insn_vs1_i    ),
    .insn_vs2_i     (insn_vs2_i    ),
    .insn_scalar_i  (insn_scalar_i ),
    .insn_ready_o   (insn_ready_o  ),
    .resp_valid_o   (resp_valid_o  ),
    .resp_data_o    (resp_data_o   ),
    .idle_o         (idle_o        ),
    .req_valid_o    (req_valid     ),
    .req_op_o       (req_op        ),
    .req_vd_o       (req_vd        ),
    .req_vs1_o      (req_vs1       ),
    .req_vs2_o      (req_vs2       ),
    .req_scalar_o   (req_scalar    ),
    .req_vl_o       (req_vl        ),
    .req_ready_i    (req_ready     ),
    .scalar_valid_i (scalar_valid  ),
    .scalar_data_i  (scalar_data   ),
    .seq_idle_i     (seq_idle      )
  );

  vproc_sequencer i_sequencer (
    .clk_i                (clk_i               ),
    .rst_n_i              (rst_n_i             ),
    .req_valid_i          (req_valid           ),
    .req_op_i             (req_op              ),
    .req_vd_i             (req_vd              ),
    .req_vs1_i            (req_vs1             ),
    .req_vs2_i            (req_vs2             ),
    .req_scalar_i         (req_scalar          ),
    .req_vl_i             (req_vl              ),
    .req_ready_o          (req_ready           ),
    .scalar_valid_o       (scalar_valid        ),
    .scalar_data_o        (scalar_data         ),
    .seq_idle_o           (seq_idle            ),
    .pe_valid_o           (pe_valid            ),
    .pe_id_o              (pe_id               ),
    .pe_op_o              (pe_op               ),
    .pe_vd_o              (pe_vd               ),
    .pe_vs1_o             (pe_vs1              ),
    .pe_vs2_o             (pe_vs2              ),
    .pe_scalar_o          (pe_scalar           ),
    .pe_vl_o              (pe_vl               ),
    .lane_ready_i         (lane_ready          ),
    .lane_done_i          (lane_done           ),
    .lane_done_id_i       (lane_done_id        ),
    .sldu_ready_i         (sldu_ready          ),
    .sldu_done_i          (sldu_done           ),
    .sldu_done_id_i       (sldu_done_id        ),
    .lane0_scalar_valid_i (lane_scalar_valid[0]),
    .lane0_scalar_data_i  (lane_scalar_data[0] )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vproc_lane #(
      .LaneId (l)
    ) i_lane (
      .clk_i          (clk_i               ),
      .rst_n_i        (rst_n_i             ),
      .pe_valid_i     (pe_valid            ),
      .pe_id_i        (pe_id               ),
      .pe_op_i        (pe_op               ),
      .pe_vd_i        (pe_vd               ),
      .pe_vs1_i       (pe_vs1              ),
      .pe_vs2_i       (pe_vs2              ),
      .pe_scalar_i    (pe_scalar           ),
      .pe_vl_i        (pe_vl               ),
      .lane_ready_o   (lane_ready[l]       ),
      .lane_done_o    (lane_done[l]        ),
      .done_id_o      (lane_done_id[l]     ),
      .rd_req_i       (rd_req[l]           ),
      .rd_vreg_i      (rd_vreg[l]          ),
      .rd_pos_i       (rd_pos[l]           ),
      .rd_data_o      (rd_data[l]          ),
      .wr_req_i       (wr_req[l]           ),
      .wr_vreg_i      (wr_vreg[l]          ),
      .wr_pos_i       (wr_pos[l]           ),
      .wr_data_i      (wr_data[l]          ),
      .scalar_valid_o (lane_scalar_valid[l]),
      .scalar_data_o  (lane_scalar_data[l] )
    );
  end : gen_lanes

  vproc_sldu i_sldu (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .pe_valid_i   (pe_valid    ),
    .pe_id_i      (pe_id       ),
    .pe_op_i      (pe_op       ),
    .pe_vd_i      (pe_vd       ),
    .pe_vs2_i     (pe_vs2      ),
    .pe_scalar_i  (pe_scalar   ),
    .pe_vl_i      (pe_vl       ),
    .sldu_ready_o (sldu_ready  ),
    .sldu_done_o  (sldu_done   ),
    .done_id_o    (sldu_done_id),
    .rd_req_o     (rd_req      ),
    .rd_vreg_o    (rd_vreg     ),
    .rd_pos_o     (rd_pos      ),
    .rd_data_i    (rd_data     ),
    .wr_req_o     (wr_req      ),
    .wr_vreg_o    (wr_vreg     ),
    .wr_pos_o     (wr_pos      ),
    .wr_data_o    (wr_data     )
  );

endmodule

// File: tests/vproc_props.sv
module vproc_props import vproc_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        insn_valid_i,
  input vop_e        insn_op_i,
  input logic        insn_ready_i,
  input logic        resp_valid_i,
  input logic        idle_i,
  input disp_state_e disp_state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  logic scalar_wait_q;

  // Set by an accepted scalar move, cleared by its response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scalar_wait_q <= 1'b0;
    end else if (insn_valid_i && insn_ready_i && insn_op_i == VMV_X_S) begin
      scalar_wait_q <= 1'b1;
    end else if (resp_valid_i) begin
      scalar_wait_q <= 1'b0;
    end
  end

  // Ready and idle straight out of reset, no stale response
  reset_state: assert property (@(posedge clk_i)
    !rst_n_i |=> (insn_ready_i && idle_i && !resp_valid_i))
    else begin
      fail_cnt++;
      $error("Top level not ready and idle after reset");
    end

  resp_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_i |=> !resp_valid_i)
    else begin
      fail_cnt++;
      $error("resp_valid_o high two cycles in a row");
    end

  // Core is held off until the scalar comes back
  ready_low_wait_scalar: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    scalar_wait_q |-> (disp_state_i == WAIT_SCALAR && !insn_ready_i))
    else begin
      fail_cnt++;
      $error("insn_ready_o high or dispatcher not waiting while a scalar is due");
    end

endmodule

bind vproc_top vproc_props i_props (
  .clk_i        (clk_i               ),
  .rst_n_i      (rst_n_i             ),
  .insn_valid_i (insn_valid_i        ),
  .insn_op_i    (insn_op_i           ),
  .insn_ready_i (insn_ready_o        ),
  .resp_valid_i (resp_valid_o        ),
  .idle_i       (idle_o              ),
  .disp_state_i (i_dispatcher.state_q)
);

// File: tests/vproc_tb.sv
`include "vproc_defs.svh"

module vproc_tb import vproc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned VlMax    = `VPROC_VLMAX;
  localparam int unsigned NrVregs  = `VPROC_NR_VREGS;
  localparam int unsigned NumTests = 5;

  localparam vreg_t V1      = vreg_t'(1);
  localparam vreg_t V2      = vreg_t'(2);
  localparam vreg_t V3      = vreg_t'(3);
  localparam vreg_t V4      = vreg_t'(4);
  localparam vreg_t V5      = vreg_t'(5);
  localparam vreg_t V6      = vreg_t'(6);
  // Holds the copy that read_vec shifts down
  localparam vreg_t Scratch = vreg_t'(NrVregs - 1);

  logic  clk_i;
  logic  rst_n_i;
  logic  insn_valid_i;
  vop_e  insn_op_i;
  vreg_t insn_vd_i;
  vreg_t insn_vs1_i;
  vreg_t insn_vs2_i;
  elem_t insn_scalar_i;
  logic  insn_ready_o;
  logic  resp_valid_o;
  elem_t resp_data_o;
  logic  idle_o;

  // Reference register file, element e at index e
  elem_t       model_q [NrVregs][VlMax];
  vlen_t       model_vl;
  elem_t       got_vec [VlMax];
  string       test_name;
  int unsigned err_cnt;
  int unsigned check_cnt;
  int          seed;

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  vproc_top vproc_top_i (
    .clk_i         (clk_i        ),
    .rst_n_i       (rst_n_i      ),
    .insn_valid_i  (insn_valid_i ),
    .insn_op_i     (insn_op_i    ),
    .insn_vd_i     (insn_vd_i    ),
    .insn_vs1_i    (insn_vs1_i   ),
    .insn_vs2_i    (insn_vs2_i   ),
    .insn_scalar_i (insn_scalar_i),
    .insn_ready_o  (insn_ready_o ),
    .resp_valid_o  (resp_valid_o ),
    .resp_data_o   (resp_data_o  ),
    .idle_o        (idle_o       )
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic elem_t rand_elem();
    return elem_t'($random(seed));
  endfunction

  // Only elements below vl change, sources are copied first
  function automatic void model_apply(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                                      elem_t scalar);
    elem_t a [VlMax];
    elem_t b [VlMax];
    for (int e = 0; e < VlMax; e++) begin
      a[e] = model_q[vs2][e];
      b[e] = model_q[vs1][e];
    end
    for (int e = 0; e < int'(model_vl); e++) begin
      case (op)
        VADD_VV:        model_q[vd][e] = a[e] + b[e];
        VAND_VV:        model_q[vd][e] = a[e] & b[e];
        VXOR_VV:        model_q[vd][e] = a[e] ^ b[e];
        VADD_VX:        model_q[vd][e] = a[e] + scalar;
        VMV_V_X:        model_q[vd][e] = scalar;
        VSLIDE1UP_VX:   model_q[vd][e] = (e == 0) ? scalar : a[e-1];
        VSLIDE1DOWN_VX: model_q[vd][e] = (e == int'(model_vl) - 1) ? scalar : a[e+1];
        default:        ;
      endcase
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_elem(string label, elem_t exp, elem_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic check_vl(string label, vlen_t exp, vlen_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, label, exp, act);
    end
  endtask

  task automatic check_bit(string label, logic exp, logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, label, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver helpers
  //////////////////////////////////////////////////////////////////////

  // Returns right after the edge that accepted the instruction
  task automatic issue(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, elem_t scalar);
    @(posedge clk_i);
    insn_valid_i  <= 1'b1;
    insn_op_i     <= op;
    insn_vd_i     <= vd;
    insn_vs1_i    <= vs1;
    insn_vs2_i    <= vs2;
    insn_scalar_i <= scalar;
    do @(negedge clk_i); while (!insn_ready_o);
    @(posedge clk_i);
    insn_valid_i <= 1'b0;
    model_apply(op, vd, vs1, vs2, scalar);
  endtask

  task automatic wait_idle();
    do @(negedge clk_i); while (!idle_o);
  endtask

  task automatic set_vl(elem_t req, vlen_t exp);
    issue(VSETVL, '0, '0, '0, req);
    model_vl = exp;
    @(negedge clk_i);
    check_bit("response one cycle after acceptance", 1'b1, resp_valid_o);
    check_vl($sformatf("vl for request %0d", req), exp, vlen_t'(resp_data_o));
  endtask

  task automatic move_scalar(vreg_t vs2, output elem_t val);
    issue(VMV_X_S, vs2, vs2, vs2, '0);
    do @(negedge clk_i); while (!resp_valid_o);
    val = resp_data_o;
  endtask

  // Needs vl at its maximum
  task automatic read_vec(vreg_t src);
    issue(VADD_VX, Scratch, src, src, '0);
    for (int e = 0; e < VlMax; e++) begin
      move_scalar(Scratch, got_vec[e]);
      issue(VSLIDE1DOWN_VX, Scratch, Scratch, Scratch, '0);
    end
  endtask

  task automatic check_vec(vreg_t src);
    string label;
    read_vec(src);
    for (int e = 0; e < VlMax; e++) begin
      label = $sformatf("v%0d[%0d]", src, e);
      check_elem(label, model_q[src][e], got_vec[e]);
    end
  endtask

  // Random data shifted in from the top, one element per slide
  task automatic load_random(vreg_t vd);
    issue(VMV_V_X, vd, vd, vd, '0);
    for (int e = 0; e < VlMax; e++) begin
      issue(VSLIDE1DOWN_VX, vd, vd, vd, rand_elem());
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    @(negedge clk_i);
    check_bit("insn_ready_o", 1'b1, insn_ready_o);
    check_bit("idle_o", 1'b1, idle_o);
    check_bit("resp_valid_o", 1'b0, resp_valid_o);
  endtask

  task automatic test_setvl_clamp();
    test_name = "setvl_clamp";
    set_vl(elem_t'(5), vlen_t'(5));
    set_vl(elem_t'(16), vlen_t'(16));
    set_vl(elem_t'(100), vlen_t'(VlMax));
  endtask

  task automatic test_arith();
    test_name = "arith";
    set_vl(elem_t'(VlMax), vlen_t'(VlMax));
    issue(VMV_V_X, V3, V3, V3, rand_elem());
    check_vec(V3);
    load_random(V1);
    load_random(V2);
    issue(VADD_VV, V3, V1, V2, '0);
    issue(VAND_VV, V4, V1, V2, '0);
    issue(VXOR_VV, V5, V1, V2, '0);
    issue(VADD_VX, V6, V1, V1, rand_elem());
    check_vec(V3);
    check_vec(V4);
    check_vec(V5);
    check_vec(V6);
  endtask

  task automatic test_slides();
    test_name = "slides";
    set_vl(elem_t'(VlMax), vlen_t'(VlMax));
    load_random(V1);
    issue(VSLIDE1UP_VX, V2, V1, V1, rand_elem());
    issue(VSLIDE1DOWN_VX, V3, V1, V1, rand_elem());
    check_vec(V2);
    check_vec(V3);
    // Short vl, the tail of v2 and v3 must survive
    load_random(V4);
    set_vl(elem_t'(6), vlen_t'(6));
    issue(VSLIDE1UP_VX, V2, V4, V4, rand_elem());
    issue(VSLIDE1DOWN_VX, V3, V4, V4, rand_elem());
    set_vl(elem_t'(VlMax), vlen_t'(VlMax));
    check_vec(V2);
    check_vec(V3);
  endtask

  task automatic test_hazards();
    test_name = "hazards";
    set_vl(elem_t'(VlMax), vlen_t'(VlMax));
    load_random(V1);
    wait_idle();
    // Each step reads what the step before wrote
    issue(VADD_VX, V2, V1, V1, rand_elem());
    issue(VSLIDE1DOWN_VX, V3, V2, V2, rand_elem());
    issue(VXOR_VV, V4, V3, V1, '0);
    issue(VSLIDE1DOWN_VX, V2, V4, V4, rand_elem());
    issue(VAND_VV, V5, V2, V4, '0);
    check_vec(V5);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 36;
    err_cnt       = 0;
    check_cnt     = 0;
    model_vl      = vlen_t'(VlMax);
    rst_n_i       = 1'b0;
    insn_valid_i  = 1'b0;
    insn_op_i     = VSETVL;
    insn_vd_i     = '0;
    insn_vs1_i    = '0;
    insn_vs2_i    = '0;
    insn_scalar_i = '0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_reset();
    test_setvl_clamp();
    test_arith();
    test_slides();
    test_hazards();
    wait_idle();

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_cnt, err_cnt, vproc_top_i.i_props.fail_cnt);
    if (err_cnt == 0 && vproc_top_i.i_props.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Generous per-test budget, a slide read takes about 200 cycles
  initial begin
    repeat (NumTests * 2000) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the DUT stopped answering", NumTests * 2000);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: files.f
+incdir+rtl
rtl/vproc_pkg.sv
rtl/vproc_dispatcher.sv
rtl/vproc_sequencer.sv
rtl/vproc_lane.sv
rtl/vproc_sldu.sv
rtl/vproc_top.sv
tests/vproc_props.sv
tests/vproc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := vproc_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
